// ==== Makefile ====
# Verilator build for the SPI peripheral testbench

VERILATOR  ?= verilator
TOP        := tb_spi_top
FILELIST   := files.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --assert -j 0
PASS_MSG   := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
spi_pkg.sv
spi_regs.sv
spi_master.sv
spi_slave.sv
spi_pin_map.sv
spi_top.sv
tb_spi_top.sv

// ==== spi_master.sv ====
// SPI master, mode 0, MSB first, one byte per transfer
// SCLK half period is clk_div+1 system clocks, 16 half periods per frame

`timescale 1ns/100ps

module spi_master import spi_pkg::*; (
   input  logic                  sys_clk,
   input  logic                  arst_n,
   input  logic                  start,
   input  logic [spi_byte_w-1:0] tx_byte,
   input  logic [7:0]            clk_div,
   output logic                  busy,
   output logic                  done,
   output logic [spi_byte_w-1:0] rx_byte,
   output logic                  sclk,
   output logic                  mosi,
   output logic                  ss,
   input  logic                  miso
);

   localparam int n_half = 2*spi_byte_w;      // Half periods per frame
   localparam int hw     = $clog2(n_half);

   logic [7:0]            div_q;              // Divider frozen for the frame
   logic [7:0]            div_cnt;
   logic [hw-1:0]         half_cnt;
   logic [spi_byte_w-1:0] sh_tx;
   logic [spi_byte_w-1:0] sh_rx;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         busy     <= 1'b0;
         done     <= 1'b0;
         sclk     <= 1'b0;
         ss       <= 1'b1;
         div_q    <= '0;
         div_cnt  <= '0;
         half_cnt <= '0;
         sh_tx    <= '0;
      end else begin
         done <= 1'b0;
         if (start && !busy) begin
            busy     <= 1'b1;
            ss       <= 1'b0;                 // Select on the cycle after start
            div_q    <= clk_div;
            div_cnt  <= clk_div;
            half_cnt <= '0;
            sh_tx    <= tx_byte;              // MSB on MOSI before first rise
         end else if (busy) begin
            if (div_cnt != '0) begin
               div_cnt <= div_cnt - 8'd1;
            end else begin
               div_cnt  <= div_q;
               sclk     <= ~sclk;
               half_cnt <= half_cnt + hw'(1);
               if (sclk) begin                // Falling edge
                  sh_tx <= {sh_tx[spi_byte_w-2:0], 1'b0};
                  if (half_cnt == hw'(n_half-1)) begin
                     busy <= 1'b0;
                     ss   <= 1'b1;
                     done <= 1'b1;
                  end
               end
            end
         end
      end
   end

   // MISO sampled at the end of the high phase
   // The slave answers through two synchronizer stages in each direction
   always_ff @(posedge sys_clk) begin
      if (busy && div_cnt == '0 && sclk)
         sh_rx <= {sh_rx[spi_byte_w-2:0], miso};
   end

   assign mosi    = sh_tx[spi_byte_w-1];
   assign rx_byte = sh_rx;                    // Complete when done pulses

   // Slower SCLK needed for the synchronized round trip
   a_div_min: assert property (@(posedge sys_clk) disable iff (!arst_n)
      start |-> clk_div >= 8'd2);

endmodule

// ==== spi_pin_map.sv ====
// SPI GPIO pin map
// Fixed pin positions and directions, two-flop synchronizers on inputs

`timescale 1ns/100ps

module spi_pin_map import spi_pkg::*; #(
   parameter int NGPIO = 24                   // At least 11 pins
) (
   input  logic             sys_clk,
   input  logic             arst_n,
   input  logic [NGPIO-1:0] gpio_i,
   output logic [NGPIO-1:0] gpio_o,
   output logic [NGPIO-1:0] gpio_oe,          // 1 = output
   input  logic             m_sclk,
   input  logic             m_mosi,
   input  logic             m_ss,
   input  logic             s_miso,
   output logic             m_miso,
   output logic             s_sclk,
   output logic             s_mosi,
   output logic             s_ss
);

   logic [3:0] sync1, sync2;                  // {s_ss, s_mosi, s_sclk, m_miso}

   always_comb begin
      gpio_o              = '0;
      gpio_o[pin_m_sclk]  = m_sclk;
      gpio_o[pin_m_mosi]  = m_mosi;
      gpio_o[pin_m_ss]    = m_ss;
      gpio_o[pin_s_miso]  = s_miso;
      gpio_oe             = '0;
      gpio_oe[pin_m_sclk] = 1'b1;
      gpio_oe[pin_m_mosi] = 1'b1;
      gpio_oe[pin_m_ss]   = 1'b1;
      gpio_oe[pin_s_miso] = 1'b1;
   end

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         sync1 <= 4'b1000;                    // Slave select idles high
         sync2 <= 4'b1000;
      end else begin
         sync1 <= {gpio_i[pin_s_ss], gpio_i[pin_s_mosi],
                   gpio_i[pin_s_sclk], gpio_i[pin_m_miso]};
         sync2 <= sync1;
      end
   end

   assign {s_ss, s_mosi, s_sclk, m_miso} = sync2;

endmodule

// ==== spi_pkg.sv ====
// SPI peripheral shared definitions
// Bus widths, register map, AXI response codes and GPIO pin positions

package spi_pkg;

   //####################################################################
   // Widths
   //####################################################################
   localparam int spi_data_w = 32;            // AXI-lite data bus
   localparam int spi_byte_w = 8;             // SPI frame

   //####################################################################
   // Register map (low address bits)
   //####################################################################
   localparam logic [4:0] reg_ctrl   = 5'h00; // [0] master enable, [15:8] divider
   localparam logic [4:0] reg_status = 5'h04; // [0] busy, [1] done, [2] slave rx
   localparam logic [4:0] reg_m_tx   = 5'h08; // Write starts a transfer
   localparam logic [4:0] reg_m_rx   = 5'h0c; // Read clears done
   localparam logic [4:0] reg_s_tx   = 5'h10; // Slave reply byte
   localparam logic [4:0] reg_s_rx   = 5'h14; // Read clears slave rx
   localparam logic [4:0] reg_irq_en = 5'h18; // [0] done, [1] slave rx

   localparam logic [1:0] resp_okay   = 2'd0;
   localparam logic [1:0] resp_slverr = 2'd2;

   //####################################################################
   // GPIO pin positions
   //####################################################################
   localparam int pin_m_sclk = 3;
   localparam int pin_m_mosi = 4;
   localparam int pin_m_miso = 5;
   localparam int pin_m_ss   = 6;
   localparam int pin_s_sclk = 7;
   localparam int pin_s_mosi = 8;
   localparam int pin_s_miso = 9;
   localparam int pin_s_ss   = 10;

endpackage

// ==== spi_regs.sv ====
// SPI register slave
// AXI4-lite single-beat register window selected by ID in the top address bits,
// holds control and transmit bytes, captures received bytes, raises interrupt

`timescale 1ns/100ps

module spi_regs import spi_pkg::*; #(
   parameter int          AW = 32,            // Address width
   parameter logic [11:0] ID = 12'h7fe        // Window ID in addr[AW-1:AW-12]
) (
   input  logic                  sys_clk,
   input  logic                  arst_n,
   // AXI-lite write
   input  logic [AW-1:0]         s_axi_awaddr,
   input  logic                  s_axi_awvalid,
   output logic                  s_axi_awready,
   input  logic [spi_data_w-1:0] s_axi_wdata,
   input  logic                  s_axi_wvalid,
   output logic                  s_axi_wready,
   output logic [1:0]            s_axi_bresp,
   output logic                  s_axi_bvalid,
   input  logic                  s_axi_bready,
   // AXI-lite read
   input  logic [AW-1:0]         s_axi_araddr,
   input  logic                  s_axi_arvalid,
   output logic                  s_axi_arready,
   output logic [spi_data_w-1:0] s_axi_rdata,
   output logic [1:0]            s_axi_rresp,
   output logic                  s_axi_rvalid,
   input  logic                  s_axi_rready,
   // Master and slave side
   output logic                  m_start,
   output logic [spi_byte_w-1:0] m_tx_byte,
   output logic [7:0]            clk_div,
   output logic [spi_byte_w-1:0] s_tx_byte,
   output logic                  irq,
   input  logic                  m_busy,
   input  logic                  m_done,
   input  logic [spi_byte_w-1:0] m_rx_byte,
   input  logic                  s_rx_strobe,
   input  logic [spi_byte_w-1:0] s_rx_byte
);

   logic                  wr_take, wr_ok;     // Write accepted, and hits a register
   logic                  rd_take, rd_ok;
   logic [4:0]            wr_off, rd_off;
   logic                  ctrl_en;            // Master enable
   logic [1:0]            irq_en;             // {slave rx, master done}
   logic                  m_done_flag;        // Sticky until reg_m_rx read
   logic                  s_rx_flag;          // Sticky until reg_s_rx read
   logic [spi_byte_w-1:0] m_rx_q, s_rx_q;
   logic [spi_data_w-1:0] rd_val;

   function automatic logic is_mapped(input logic [4:0] off);
      return off inside {reg_ctrl, reg_status, reg_m_tx, reg_m_rx,
                         reg_s_tx, reg_s_rx, reg_irq_en};
   endfunction

   //####################################################################
   // Write channel
   //####################################################################
   assign wr_take       = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
   assign s_axi_awready = wr_take;            // Address and data taken together
   assign s_axi_wready  = wr_take;
   assign wr_off        = s_axi_awaddr[4:0];
   assign wr_ok         = wr_take & (s_axi_awaddr[AW-1:AW-12] == ID) & is_mapped(wr_off);

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         s_axi_bvalid <= 1'b0;
         s_axi_bresp  <= resp_okay;
         m_start      <= 1'b0;
         ctrl_en      <= 1'b0;
         clk_div      <= '0;
         s_tx_byte    <= '0;
         irq_en       <= '0;
      end else begin
         m_start <= 1'b0;                     // Single-cycle pulse
         if (s_axi_bvalid && s_axi_bready)
            s_axi_bvalid <= 1'b0;
         if (wr_take) begin
            s_axi_bvalid <= 1'b1;             // Response on the next cycle
            s_axi_bresp  <= wr_ok ? resp_okay : resp_slverr;
         end
         if (wr_ok) begin
            case (wr_off)
               reg_ctrl: begin
                  ctrl_en <= s_axi_wdata[0];
                  clk_div <= s_axi_wdata[15:8];
               end
               reg_m_tx:   m_start <= ctrl_en & ~m_busy & ~m_start; // Dropped while busy
               reg_s_tx:   s_tx_byte <= s_axi_wdata[spi_byte_w-1:0];
               reg_irq_en: irq_en <= s_axi_wdata[1:0];
               default: ;                     // Read-only offsets
            endcase
         end
      end
   end

   // Transmit byte only follows an accepted start
   always_ff @(posedge sys_clk) begin
      if (wr_ok && wr_off == reg_m_tx && ctrl_en && !m_busy && !m_start)
         m_tx_byte <= s_axi_wdata[spi_byte_w-1:0];
   end

   //####################################################################
   // Status flags and received bytes
   //####################################################################
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         m_done_flag <= 1'b0;
         s_rx_flag   <= 1'b0;
      end else begin
         if (m_done)
            m_done_flag <= 1'b1;              // Set wins over a clearing read
         else if (rd_ok && rd_off == reg_m_rx)
            m_done_flag <= 1'b0;
         if (s_rx_strobe)
            s_rx_flag <= 1'b1;
         else if (rd_ok && rd_off == reg_s_rx)
            s_rx_flag <= 1'b0;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (m_done)
         m_rx_q <= m_rx_byte;
      if (s_rx_strobe)
         s_rx_q <= s_rx_byte;
   end

   assign irq = |({s_rx_flag, m_done_flag} & irq_en);

   //####################################################################
   // Read channel
   //####################################################################
   assign rd_take       = s_axi_arvalid & ~s_axi_rvalid;
   assign s_axi_arready = rd_take;
   assign rd_off        = s_axi_araddr[4:0];
   assign rd_ok         = rd_take & (s_axi_araddr[AW-1:AW-12] == ID) & is_mapped(rd_off);

   always_comb begin
      rd_val = '0;
      case (rd_off)
         reg_ctrl: begin
            rd_val[0]    = ctrl_en;
            rd_val[15:8] = clk_div;
         end
         reg_status: rd_val[2:0]            = {s_rx_flag, m_done_flag, m_busy};
         reg_m_tx:   rd_val[spi_byte_w-1:0] = m_tx_byte;
         reg_m_rx:   rd_val[spi_byte_w-1:0] = m_rx_q;
         reg_s_tx:   rd_val[spi_byte_w-1:0] = s_tx_byte;
         reg_s_rx:   rd_val[spi_byte_w-1:0] = s_rx_q;
         reg_irq_en: rd_val[1:0]            = irq_en;
         default: ;
      endcase
   end

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         s_axi_rvalid <= 1'b0;
         s_axi_rresp  <= resp_okay;
      end else begin
         if (s_axi_rvalid && s_axi_rready)
            s_axi_rvalid <= 1'b0;
         if (rd_take) begin
            s_axi_rvalid <= 1'b1;
            s_axi_rresp  <= rd_ok ? resp_okay : resp_slverr;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rd_take)
         s_axi_rdata <= rd_ok ? rd_val : '0;  // Zero on error
   end

   // Write response held until accepted
   a_bvalid_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

   // No start reaches a master that is mid-frame
   a_start_idle: assert property (@(posedge sys_clk) disable iff (!arst_n)
      m_start |-> !m_busy);

endmodule

// ==== spi_slave.sv ====
// SPI slave, mode 0, runs on system clock from synchronized pins
// Returns a preloaded byte and captures the incoming one

`timescale 1ns/100ps

module spi_slave import spi_pkg::*; (
   input  logic                  sys_clk,
   input  logic                  arst_n,
   input  logic                  sclk,        // Already synchronized
   input  logic                  mosi,
   input  logic                  ss,
   input  logic [spi_byte_w-1:0] tx_byte,
   output logic                  miso,
   output logic                  rx_strobe,
   output logic [spi_byte_w-1:0] rx_byte
);

   logic                  sclk_q, ss_q;       // Previous samples for edge detect
   logic                  sclk_rise, sclk_fall;
   logic                  ss_fall, ss_rise;
   logic [3:0]            bit_cnt;            // Saturates on overlong frames
   logic [spi_byte_w-1:0] sh_tx;
   logic [spi_byte_w-1:0] sh_rx;

   assign sclk_rise = sclk & ~sclk_q;
   assign sclk_fall = ~sclk & sclk_q;
   assign ss_fall   = ~ss & ss_q;
   assign ss_rise   = ss & ~ss_q;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         sclk_q    <= 1'b0;
         ss_q      <= 1'b1;
         bit_cnt   <= '0;
         sh_tx     <= '1;                     // Idle MISO high
         rx_strobe <= 1'b0;
      end else begin
         sclk_q    <= sclk;
         ss_q      <= ss;
         rx_strobe <= 1'b0;
         if (ss_fall) begin
            sh_tx   <= tx_byte;
            bit_cnt <= '0;
         end else if (ss_rise) begin
            rx_strobe <= (bit_cnt == 4'd8);   // Short or long frame dropped
            sh_tx     <= '1;
         end else if (!ss) begin
            if (sclk_rise && bit_cnt != 4'hf)
               bit_cnt <= bit_cnt + 4'd1;
            if (sclk_fall)
               sh_tx <= {sh_tx[spi_byte_w-2:0], 1'b1};
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!ss && sclk_rise)
         sh_rx <= {sh_rx[spi_byte_w-2:0], mosi};
   end

   assign miso    = sh_tx[spi_byte_w-1];
   assign rx_byte = sh_rx;                    // Valid with rx_strobe

endmodule

// ==== spi_top.sv ====
// SPI peripheral top
// AXI4-lite register window with SPI master and slave on GPIO pins

`timescale 1ns/100ps

module spi_top import spi_pkg::*; #(
   parameter int          AW    = 32,         // Address width
   parameter logic [11:0] ID    = 12'h7fe,    // Window ID
   parameter int          NGPIO = 24          // Number of GPIO pins
) (
   input  logic                  sys_clk,
   input  logic                  arst_n,
   input  logic [AW-1:0]         s_axi_awaddr,
   input  logic                  s_axi_awvalid,
   output logic                  s_axi_awready,
   input  logic [spi_data_w-1:0] s_axi_wdata,
   input  logic                  s_axi_wvalid,
   output logic                  s_axi_wready,
   output logic [1:0]            s_axi_bresp,
   output logic                  s_axi_bvalid,
   input  logic                  s_axi_bready,
   input  logic [AW-1:0]         s_axi_araddr,
   input  logic                  s_axi_arvalid,
   output logic                  s_axi_arready,
   output logic [spi_data_w-1:0] s_axi_rdata,
   output logic [1:0]            s_axi_rresp,
   output logic                  s_axi_rvalid,
   input  logic                  s_axi_rready,
   input  logic [NGPIO-1:0]      gpio_i,
   output logic [NGPIO-1:0]      gpio_o,
   output logic [NGPIO-1:0]      gpio_oe,
   output logic                  irq
);

   // Register block to engines
   logic                  m_start, m_busy, m_done;
   logic [spi_byte_w-1:0] m_tx_byte, m_rx_byte;
   logic [7:0]            clk_div;
   logic                  s_rx_strobe;
   logic [spi_byte_w-1:0] s_tx_byte, s_rx_byte;

   // Engines to pins
   logic                  m_sclk, m_mosi, m_ss, m_miso;
   logic                  s_sclk, s_mosi, s_ss, s_miso;

   spi_regs #(.AW(AW), .ID(ID)) regs0 (
      .sys_clk       (sys_clk),
      .arst_n        (arst_n),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .m_start       (m_start),
      .m_tx_byte     (m_tx_byte),
      .clk_div       (clk_div),
      .s_tx_byte     (s_tx_byte),
      .irq           (irq),
      .m_busy        (m_busy),
      .m_done        (m_done),
      .m_rx_byte     (m_rx_byte),
      .s_rx_strobe   (s_rx_strobe),
      .s_rx_byte     (s_rx_byte)
   );

   spi_master master0 (
      .sys_clk (sys_clk),
      .arst_n  (arst_n),
      .start   (m_start),
      .tx_byte (m_tx_byte),
      .clk_div (clk_div),
      .busy    (m_busy),
      .done    (m_done),
      .rx_byte (m_rx_byte),
      .sclk    (m_sclk),
      .mosi    (m_mosi),
      .ss      (m_ss),
      .miso    (m_miso)
   );

   spi_slave slave0 (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .sclk      (s_sclk),
      .mosi      (s_mosi),
      .ss        (s_ss),
      .tx_byte   (s_tx_byte),
      .miso      (s_miso),
      .rx_strobe (s_rx_strobe),
      .rx_byte   (s_rx_byte)
   );

   spi_pin_map #(.NGPIO(NGPIO)) pins0 (
      .sys_clk (sys_clk),
      .arst_n  (arst_n),
      .gpio_i  (gpio_i),
      .gpio_o  (gpio_o),
      .gpio_oe (gpio_oe),
      .m_sclk  (m_sclk),
      .m_mosi  (m_mosi),
      .m_ss    (m_ss),
      .s_miso  (s_miso),
      .m_miso  (m_miso),
      .s_sclk  (s_sclk),
      .s_mosi  (s_mosi),
      .s_ss    (s_ss)
   );

endmodule

// ==== tb_spi_top.sv ====
// Testbench for the SPI peripheral
// AXI-lite register accesses, GPIO loopback from master pins to slave pins,
// register model as reference, queued checks compared on the falling edge

`timescale 1ns/100ps

module tb_spi_top import spi_pkg::*; ();

   localparam int          aw         = 32;
   localparam int          ngpio      = 24;
   localparam logic [11:0] win_id     = 12'h7fe;
   localparam int          hs_limit   = 50;   // Cycles per handshake
   localparam int          poll_limit = 100;  // Status reads per transfer
   localparam int          irq_limit  = 400;  // Cycles until irq

   logic                  sys_clk = 1'b0;
   logic                  arst_n;
   logic [aw-1:0]         s_axi_awaddr, s_axi_araddr;
   logic                  s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
   logic [spi_data_w-1:0] s_axi_wdata, s_axi_rdata;
   logic [1:0]            s_axi_bresp, s_axi_rresp;
   logic                  s_axi_bvalid, s_axi_bready;
   logic                  s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
   logic [ngpio-1:0]      gpio_i, gpio_o, gpio_oe, oe_exp;
   logic                  irq;

   // Register model
   logic       mdl_en, mdl_busy, mdl_done, mdl_srx;
   logic [7:0] mdl_div, mdl_m_tx, mdl_m_rx, mdl_s_tx, mdl_s_rx;
   logic [1:0] mdl_irq_en;

   logic [33:0] act_q[$];                     // {resp, data} pairs
   logic [33:0] exp_q[$];
   string       msg_q[$];
   int          n_checks = 0;
   logic [31:0] rng = 32'h5b7de1b8;

   always #10 sys_clk = ~sys_clk;             // 20 ns period

   spi_top #(.AW(aw), .ID(win_id), .NGPIO(ngpio)) dut0 (
      .sys_clk(sys_clk), .arst_n(arst_n),
      .s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
      .s_axi_awready(s_axi_awready), .s_axi_wdata(s_axi_wdata),
      .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
      .s_axi_bresp(s_axi_bresp), .s_axi_bvalid(s_axi_bvalid),
      .s_axi_bready(s_axi_bready), .s_axi_araddr(s_axi_araddr),
      .s_axi_arvalid(s_axi_arvalid), .s_axi_arready(s_axi_arready),
      .s_axi_rdata(s_axi_rdata), .s_axi_rresp(s_axi_rresp),
      .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
      .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe(gpio_oe), .irq(irq)
   );

   // Board wiring loops master pins back to slave pins
   always_comb begin
      gpio_i             = '0;
      gpio_i[pin_s_sclk] = gpio_o[pin_m_sclk];
      gpio_i[pin_s_mosi] = gpio_o[pin_m_mosi];
      gpio_i[pin_s_ss]   = gpio_o[pin_m_ss];
      gpio_i[pin_m_miso] = gpio_o[pin_s_miso];
   end

   //####################################################################
   // Reference model and helpers
   //####################################################################
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] reg_addr(input logic [4:0] off);
      return {win_id, 15'h0, off};
   endfunction

   function automatic logic [31:0] bad_addr(input logic [4:0] off);
      return {12'h123, 15'h0, off};           // Foreign window
   endfunction

   // Expected {resp, data} of a read
   // The resp field also applies to a write
   function automatic logic [33:0] expect_read(input logic [31:0] addr);
      logic [31:0] d;
      d = '0;
      if (addr[31:20] != win_id)
         return {resp_slverr, 32'h0};
      case (addr[4:0])
         reg_ctrl:   d = {16'h0, mdl_div, 7'h0, mdl_en};
         reg_status: d = {29'h0, mdl_srx, mdl_done, mdl_busy};
         reg_m_tx:   d = {24'h0, mdl_m_tx};
         reg_m_rx:   d = {24'h0, mdl_m_rx};
         reg_s_tx:   d = {24'h0, mdl_s_tx};
         reg_s_rx:   d = {24'h0, mdl_s_rx};
         reg_irq_en: d = {30'h0, mdl_irq_en};
         default:    return {resp_slverr, 32'h0};
      endcase
      return {resp_okay, d};
   endfunction

   task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
      logic [33:0] r;
      r = expect_read(addr);
      if (r[33:32] == resp_okay) begin
         case (addr[4:0])
            reg_ctrl: begin
               mdl_en  = data[0];
               mdl_div = data[15:8];
            end
            reg_m_tx: begin
               if (mdl_en && !mdl_busy) begin // Byte exchange of one frame
                  mdl_m_tx = data[7:0];
                  mdl_busy = 1'b1;
                  mdl_m_rx = mdl_s_tx;
                  mdl_s_rx = data[7:0];
               end
            end
            reg_s_tx:   mdl_s_tx   = data[7:0];
            reg_irq_en: mdl_irq_en = data[1:0];
            default: ;
         endcase
      end
   endtask

   task automatic queue_check(input logic [33:0] act, input logic [33:0] exp_val,
                              input string msg);
      act_q.push_back(act);
      exp_q.push_back(exp_val);
      msg_q.push_back(msg);
   endtask

   task automatic timeout_abort(input string what);
      $display("TIMEOUT at %0t waiting for %s", $time, what);
      $display("tests failed");
      $fatal(1, "simulation stopped on timeout");
   endtask

   //####################################################################
   // AXI-lite bus driver
   //####################################################################
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int n;
      s_axi_awaddr  = addr;
      s_axi_wdata   = data;
      s_axi_awvalid = 1'b1;
      s_axi_wvalid  = 1'b1;
      n = 0;
      @(negedge sys_clk);
      while (!(s_axi_awready && s_axi_wready)) begin
         if (n == hs_limit) timeout_abort("write address and data accept");
         n++;
         @(negedge sys_clk);
      end
      @(posedge sys_clk);                     // Taken on this edge
      #2;
      s_axi_awvalid = 1'b0;
      s_axi_wvalid  = 1'b0;
      n = 0;
      @(negedge sys_clk);
      while (!s_axi_bvalid) begin
         if (n == hs_limit) timeout_abort("write response");
         n++;
         @(negedge sys_clk);
      end
      resp = s_axi_bresp;
      @(posedge sys_clk);                     // bready held high
      #2;
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int n;
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      n = 0;
      @(negedge sys_clk);
      while (!s_axi_arready) begin
         if (n == hs_limit) timeout_abort("read address accept");
         n++;
         @(negedge sys_clk);
      end
      @(posedge sys_clk);
      #2;
      s_axi_arvalid = 1'b0;
      n = 0;
      @(negedge sys_clk);
      while (!s_axi_rvalid) begin
         if (n == hs_limit) timeout_abort("read data");
         n++;
         @(negedge sys_clk);
      end
      data = s_axi_rdata;
      resp = s_axi_rresp;
      @(posedge sys_clk);
      #2;
   endtask

   task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
      logic [1:0]  resp;
      logic [33:0] e;
      e = expect_read(addr);
      bus_write(addr, data, resp);
      queue_check({32'h0, resp}, {32'h0, e[33:32]}, $sformatf("write resp at %h", addr));
      model_write(addr, data);
   endtask

   task automatic check_read(input logic [31:0] addr);
      logic [31:0] d;
      logic [1:0]  resp;
      logic [33:0] e;
      e = expect_read(addr);
      bus_read(addr, d, resp);
      queue_check({resp, d}, e, $sformatf("read at %h", addr));
      if (e[33:32] == resp_okay && addr[4:0] == reg_m_rx)
         mdl_done = 1'b0;                     // Read clears sticky flags
      if (e[33:32] == resp_okay && addr[4:0] == reg_s_rx)
         mdl_srx = 1'b0;
   endtask

   //####################################################################
   // Transfer sequences
   //####################################################################
   task automatic start_transfer(input logic [7:0] m_byte, input logic [7:0] s_byte,
                                 input logic [7:0] div);
      reg_write(reg_addr(reg_s_tx), {24'h0, s_byte});
      reg_write(reg_addr(reg_ctrl), {16'h0, div, 8'h01});
      reg_write(reg_addr(reg_m_tx), {24'hffffff, m_byte}); // Upper bits unused
   endtask

   // Poll until master idle and slave byte captured
   task automatic wait_transfer();
      logic [31:0] st;
      logic [1:0]  resp;
      int          n;
      n  = 0;
      st = 32'h1;
      while (st[0] || !st[2]) begin
         if (n == poll_limit) timeout_abort("transfer to finish");
         bus_read(reg_addr(reg_status), st, resp);
         queue_check({32'h0, resp}, {32'h0, resp_okay}, "status poll response");
         n++;
      end
      mdl_busy = 1'b0;
      mdl_done = 1'b1;
      mdl_srx  = 1'b1;
      check_read(reg_addr(reg_status));
   endtask

   task automatic read_results();
      check_read(reg_addr(reg_m_rx));
      check_read(reg_addr(reg_status));
      check_read(reg_addr(reg_s_rx));
      check_read(reg_addr(reg_status));
   endtask

   task automatic wait_irq();
      int n;
      n = 0;
      @(negedge sys_clk);
      while (!irq) begin
         if (n == irq_limit) timeout_abort("irq to rise");
         n++;
         @(negedge sys_clk);
      end
      @(posedge sys_clk);
      #2;
   endtask

   //####################################################################
   // Comparison
   //####################################################################
   always @(negedge sys_clk) begin : compare_results
      logic [33:0] act_v, exp_v;
      string       msg;
      while (act_q.size() != 0) begin
         act_v = act_q.pop_front();
         exp_v = exp_q.pop_front();
         msg   = msg_q.pop_front();
         n_checks++;
         assert (act_v === exp_v) else begin
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, act_v, exp_v);
            $display("tests failed");
            $fatal(1, "stopped at first error");
         end
      end
   end

   //####################################################################
   // Stimulus
   //####################################################################
   initial begin
      arst_n        = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b1;                   // Responses always taken
      s_axi_araddr  = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b1;
      {mdl_en, mdl_busy, mdl_done, mdl_srx} = '0;
      {mdl_div, mdl_m_tx, mdl_m_rx, mdl_s_tx, mdl_s_rx} = '0;
      mdl_irq_en = '0;
      repeat (5) @(posedge sys_clk);
      #2;
      arst_n = 1'b1;
      @(posedge sys_clk);
      #2;

      $display("[%0t] reset state", $time);
      oe_exp       = '0;
      oe_exp[11:0] = 12'b0010_0101_1000;      // Pins 3, 4, 6 and 9 drive
      queue_check(34'(gpio_oe), 34'(oe_exp), "gpio_oe direction pattern");
      queue_check(34'(irq), 34'(1'b0), "irq after reset");
      queue_check(34'(gpio_o[pin_m_ss]), 34'(1'b1), "master SS idle high");
      check_read(reg_addr(reg_status));

      $display("[%0t] register access and decode", $time);
      reg_write(reg_addr(reg_ctrl), 32'hffff_ff03);
      check_read(reg_addr(reg_ctrl));
      reg_write(reg_addr(reg_s_tx), 32'h1234_56c3);
      check_read(reg_addr(reg_s_tx));
      reg_write(reg_addr(reg_irq_en), 32'hffff_fffe);
      check_read(reg_addr(reg_irq_en));
      reg_write(bad_addr(reg_s_tx), 32'h0000_0055); // Must not land
      check_read(reg_addr(reg_s_tx));
      check_read(bad_addr(reg_ctrl));
      reg_write(reg_addr(5'h1c), 32'h1);
      check_read(reg_addr(5'h1c));
      check_read(reg_addr(5'h02));
      reg_write(reg_addr(reg_irq_en), 32'h0);

      $display("[%0t] random byte exchanges", $time);
      for (int i = 0; i < 20; i++) begin
         rng = xorshift32(rng);
         start_transfer(rng[7:0], rng[15:8], 8'd2 + {6'h0, rng[17:16]});
         wait_transfer();
         read_results();
      end

      $display("[%0t] interrupts", $time);
      reg_write(reg_addr(reg_irq_en), 32'h1);  // Master done only
      rng = xorshift32(rng);
      start_transfer(rng[7:0], rng[15:8], 8'd3);
      wait_irq();
      wait_transfer();
      queue_check(34'(irq), 34'(1'b1), "irq held until m_rx read");
      check_read(reg_addr(reg_m_rx));
      queue_check(34'(irq), 34'(1'b0), "irq cleared by m_rx read");
      check_read(reg_addr(reg_s_rx));
      reg_write(reg_addr(reg_irq_en), 32'h2);  // Slave received only
      rng = xorshift32(rng);
      start_transfer(rng[7:0], rng[15:8], 8'd2);
      wait_irq();
      wait_transfer();
      check_read(reg_addr(reg_s_rx));
      queue_check(34'(irq), 34'(1'b0), "irq cleared by s_rx read");
      check_read(reg_addr(reg_m_rx));
      reg_write(reg_addr(reg_irq_en), 32'h0);
      rng = xorshift32(rng);
      start_transfer(rng[7:0], rng[15:8], 8'd4);
      wait_transfer();
      queue_check(34'(irq), 34'(1'b0), "irq with enables clear");
      read_results();

      $display("[%0t] write to busy master", $time);
      rng = xorshift32(rng);
      start_transfer(rng[7:0], rng[15:8], 8'd5);
      reg_write(reg_addr(reg_m_tx), {24'h0, ~rng[7:0]}); // Dropped while the frame runs
      check_read(reg_addr(reg_m_tx));
      wait_transfer();
      read_results();

      @(posedge sys_clk);                     // Let the last checks drain
      @(posedge sys_clk);
      if (act_q.size() == 0 && n_checks > 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule
